/* build.f */
+incdir+.
core_isa_pkg.sv
l15_pkg.sv
debug_loader.sv
instr_decode.sv
execute_unit.sv
result_writeback.sv
core_top.sv
tb_core_asserts.sv
tb_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_core
FLIST ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

/* tb_core.sv */
`timescale 1ns/100ps

module tb_core import core_isa_pkg::*, l15_pkg::*;;

localparam int NUM_INSTR = 40;
localparam int HALT_ADDR = NUM_INSTR;
// Reset, program load, then per instruction 3 cycles plus worst memory wait
localparam int TIMEOUT_CYCLES = 16 + (NUM_INSTR + 1) + 10 + (NUM_INSTR + 1) * (3 + 8) + 100;

typedef struct packed {
	logic        is_store;
	logic [31:0] addr;
	logic [31:0] data;
} memop_t;

logic            clk;
logic            rst;
logic            load_we;
logic [PC_W-1:0] load_addr;
logic [31:0]     load_instr;
logic            go;
l15_req_t        transducer_l15_req;
logic            transducer_l15_val;
logic            l15_transducer_header_ack;
l15_resp_t       l15_transducer_resp;
logic            l15_transducer_val;
logic            transducer_l15_req_ack;
logic            retire_valid;
retire_t         retire;
logic            halted;

logic [31:0] rng;
logic [31:0] program_words [NUM_INSTR + 1];
logic [31:0] mem_init [16];
logic [31:0] l15_mem [16]; // Memory behind the L1.5 port
retire_t     exp_retires [$];
memop_t      exp_memops [$];
int          errors;
int          checks;
int          cycles;
logic        halt_seen;

core_top core_top_i (
	.clk(clk),
	.rst(rst),
	.load_we(load_we),
	.load_addr(load_addr),
	.load_instr(load_instr),
	.go(go),
	.transducer_l15_req(transducer_l15_req),
	.transducer_l15_val(transducer_l15_val),
	.l15_transducer_header_ack(l15_transducer_header_ack),
	.l15_transducer_resp(l15_transducer_resp),
	.l15_transducer_val(l15_transducer_val),
	.transducer_l15_req_ack(transducer_l15_req_ack),
	.retire_valid(retire_valid),
	.retire(retire),
	.halted(halted)
);

initial
begin
	clk = 1'b0;
	forever
		#4 clk = ~clk;
end

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic logic [31:0] next_random();
	rng = xorshift32(rng);
	return rng;
endfunction

task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
	checks++;
	if (actual !== expected)
	begin
		errors++;
		$display("[FAIL] %0t %s: got %h expected %h", $time, name, actual, expected);
	end
endtask

task automatic report_error(input string msg);
	errors++;
	$display("Error at %0t: %s", $time, msg);
endtask

// Random program, last word is HALT
task automatic generate_program();
	logic [31:0] r;
	logic [3:0]  op;
	logic [3:0]  rd;
	logic [3:0]  rs1;
	logic [3:0]  rs2;
	logic [15:0] imm;
	for (int i = 0; i < NUM_INSTR; i++)
	begin
		r = next_random();
		rd = r[7:4];
		rs1 = r[11:8];
		rs2 = r[15:12];
		imm = r[31:16];
		case (r[3:0] % 10)
			0, 1, 2, 3, 4: op = 4'(ADD + r[3:0] % 10);
			5:             op = ADDI;
			6:             op = LUI;
			7, 8:
			begin
				op = (r[3:0] % 10 == 7) ? LD : ST;
				rs1 = 4'h0; // Address from immediate only
				imm = {10'h0, r[19:16], 2'b00};
			end
			default:
			begin
				op = BEQ;
				if (r[20])
					rs2 = rs1; // Always taken
				imm = (i <= HALT_ADDR - 4) ? 16'(2 + r[18:16] % 3) : 16'(HALT_ADDR - i);
			end
		endcase
		if (i == 0)
		begin
			op = ADDI; // Write to r0 that must not stick
			rd = 4'h0;
		end
		program_words[i] = {op, rd, rs1, rs2, imm};
	end
	program_words[HALT_ADDR] = {HALT, 28'h0};
endtask

// Reference interpreter of the instruction set
task automatic run_model();
	logic [31:0]     regs [16];
	logic [31:0]     mem [16];
	logic [31:0]     w;
	logic [31:0]     a;
	logic [31:0]     b;
	logic [31:0]     sext;
	logic [31:0]     res;
	logic [PC_W-1:0] pc;
	logic            writes;
	int              steps;
	for (int i = 0; i < 16; i++)
	begin
		regs[i] = 32'h0;
		mem[i] = mem_init[i];
	end
	pc = '0;
	steps = 0;
	while (steps < 200)
	begin
		w = program_words[pc];
		a = regs[w[23:20]];
		b = regs[w[19:16]];
		sext = {{16{w[15]}}, w[15:0]};
		writes = 1'b1;
		res = 32'h0;
		steps++;
		if (w[31:28] == HALT)
			break;
		case (w[31:28])
			ADD:  res = a + b;
			SUB:  res = a - b;
			AND:  res = a & b;
			OR:   res = a | b;
			XOR:  res = a ^ b;
			ADDI: res = a + sext;
			LUI:  res = {w[15:0], 16'h0};
			LD:
			begin
				res = mem[(a + sext) >> 2 & 32'hf];
				exp_memops.push_back('{1'b0, a + sext, 32'h0});
			end
			ST:
			begin
				writes = 1'b0;
				mem[(a + sext) >> 2 & 32'hf] = b;
				exp_memops.push_back('{1'b1, a + sext, b});
			end
			default: writes = 1'b0;
		endcase
		if (writes)
		begin
			exp_retires.push_back('{w[27:24], res, pc});
			if (w[27:24] != 4'h0)
				regs[w[27:24]] = res;
		end
		if (w[31:28] == BEQ && a == b)
			pc = pc + w[PC_W-1:0];
		else
			pc = pc + 1'b1;
	end
endtask

// L1.5 memory model with random header_ack and response delays
initial
begin
	memop_t exp;
	int     d;
	forever
	begin
		@(posedge clk);
		#1;
		if (transducer_l15_val && !rst)
		begin
			if (exp_memops.size() == 0)
				report_error("L1.5 request with no memory operation left in the model");
			else
			begin
				exp = exp_memops.pop_front();
				check_value("req.rqtype", transducer_l15_req.rqtype,
					exp.is_store ? STORE_RQ : LOAD_RQ);
				check_value("req.address", transducer_l15_req.address, exp.addr);
				check_value("req.size", transducer_l15_req.size, 3'b010);
				if (exp.is_store)
					check_value("req.data", transducer_l15_req.data[31:0], exp.data);
			end
			d = next_random() % 4;
			repeat (d)
			begin
				@(posedge clk);
				#1;
			end
			l15_transducer_header_ack = 1'b1; // Zero delay acks in the first val cycle
			@(posedge clk);
			#1 l15_transducer_header_ack = 1'b0;
			if (transducer_l15_req.rqtype == STORE_RQ)
				l15_mem[transducer_l15_req.address[5:2]] = transducer_l15_req.data[31:0];
			d = 1 + next_random() % 4;
			repeat (d - 1)
			begin
				@(posedge clk);
				#1;
			end
			l15_transducer_val = 1'b1;
			if (transducer_l15_req.rqtype == STORE_RQ)
				l15_transducer_resp = '{ST_ACK, 64'h0};
			else
				l15_transducer_resp = '{LOAD_RET,
					{next_random(), l15_mem[transducer_l15_req.address[5:2]]}};
			@(posedge clk);
			#1 l15_transducer_val = 1'b0;
			@(negedge clk);
			check_value("transducer_l15_req_ack", transducer_l15_req_ack, 1'b1);
		end
	end
end

// Retire and post-halt monitor
always @(negedge clk)
begin
	retire_t exp;
	if (!rst)
	begin
		if (halt_seen && (retire_valid || transducer_l15_val))
			report_error("retire or request seen after halt");
		if (retire_valid)
		begin
			if (exp_retires.size() == 0)
				report_error("retire with no retire left in the model");
			else
			begin
				exp = exp_retires.pop_front();
				check_value("retire.rd", retire.rd, exp.rd);
				check_value("retire.data", retire.data, exp.data);
				check_value("retire.pc", retire.pc, exp.pc);
			end
		end
		if (halted)
			halt_seen = 1'b1;
	end
end

always @(posedge clk)
begin
	cycles++;
	if (cycles > TIMEOUT_CYCLES)
	begin
		$display("Timeout: core did not halt within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end
end

initial
begin
	rst = 1'b1;
	load_we = 1'b0;
	load_addr = '0;
	load_instr = 32'h0;
	go = 1'b0;
	l15_transducer_header_ack = 1'b0;
	l15_transducer_resp = '0;
	l15_transducer_val = 1'b0;
	errors = 0;
	checks = 0;
	cycles = 0;
	halt_seen = 1'b0;
	rng = 32'h31cb8474;

	for (int i = 0; i < 16; i++)
	begin
		mem_init[i] = next_random();
		l15_mem[i] = mem_init[i];
	end
	generate_program();
	run_model();

	repeat (16)
		@(posedge clk);
	#1 rst = 1'b0;

	for (int i = 0; i <= NUM_INSTR; i++)
	begin
		@(posedge clk);
		#1 load_we = 1'b1;
		load_addr = PC_W'(i);
		load_instr = program_words[i];
	end
	@(posedge clk);
	#1 load_we = 1'b0;
	@(posedge clk);
	#1 go = 1'b1;
	@(posedge clk);
	#1 go = 1'b0;
	// Late write of HALT to address 5 must be ignored while running
	@(posedge clk);
	@(posedge clk);
	#1 load_we = 1'b1;
	load_addr = PC_W'(5);
	load_instr = {HALT, 28'h0};
	@(posedge clk);
	#1 load_we = 1'b0;

	while (!halted)
		@(posedge clk);
	repeat (20)
		@(posedge clk);
	check_value("halted", halted, 1'b1);
	if (exp_retires.size() != 0)
		report_error("core halted before all model retires appeared");
	if (exp_memops.size() != 0)
		report_error("core halted before all model memory requests appeared");

	$display("Checks: %0d, errors: %0d", checks, errors);
	if (errors == 0)
		$display("Simulation passed");
	else
		$display("Simulation failed");
	$finish;
end

endmodule

/* tb_core_asserts.sv */
`timescale 1ns/100ps

module tb_core_asserts import l15_pkg::*; (
	input logic     clk,
	input logic     rst,
	input logic     start,
	input logic     fetch_en,
	input l15_req_t transducer_l15_req,
	input logic     transducer_l15_val,
	input logic     l15_transducer_header_ack,
	input logic     l15_transducer_val,
	input logic     transducer_l15_req_ack,
	input logic     wb_valid,
	input logic     halted
);

// Request held stable until header acknowledge
assert property (@(posedge clk) disable iff (rst)
	transducer_l15_val && !l15_transducer_header_ack
	|=> transducer_l15_val && $stable(transducer_l15_req))
	else $error("L1.5 request dropped or changed before header ack");

assert property (@(posedge clk) disable iff (rst)
	transducer_l15_val && l15_transducer_header_ack |=> !transducer_l15_val)
	else $error("L1.5 val still high after header ack");

assert property (@(posedge clk) disable iff (rst)
	l15_transducer_val |=> transducer_l15_req_ack)
	else $error("No req_ack after response");

assert property (@(posedge clk) disable iff (rst) start |=> start)
	else $error("start fell without reset");

assert property (@(posedge clk) disable iff (rst)
	halted |=> halted && !fetch_en && !transducer_l15_val && !wb_valid)
	else $error("Activity after halt");

endmodule

bind execute_unit tb_core_asserts tb_core_asserts_i (.*);

/* core_top.sv */
`timescale 1ns/100ps

module core_top import core_isa_pkg::*, l15_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            load_we,
	input  logic [PC_W-1:0] load_addr,
	input  logic [31:0]     load_instr,
	input  logic            go,
	output l15_req_t        transducer_l15_req,
	output logic            transducer_l15_val,
	input  logic            l15_transducer_header_ack,
	input  l15_resp_t       l15_transducer_resp,
	input  logic            l15_transducer_val,
	output logic            transducer_l15_req_ack,
	output logic            retire_valid,
	output retire_t         retire,
	output logic            halted
);

logic              imem_we;
logic [PC_W-1:0]   imem_addr;
logic [31:0]       imem_data;
logic              start;
logic              fetch_en;
logic              branch_taken;
logic [PC_W-1:0]   branch_target;
decoded_t          dec;
logic              dec_valid;
logic [REG_AW-1:0] rs1_addr;
logic [REG_AW-1:0] rs2_addr;
logic [31:0]       rs1_data;
logic [31:0]       rs2_data;
logic              wb_valid;
retire_t           wb;

debug_loader debug_loader_i (
	.clk(clk),
	.rst(rst),
	.load_we(load_we),
	.go(go),
	.load_addr(load_addr),
	.load_instr(load_instr),
	.imem_we(imem_we),
	.imem_addr(imem_addr),
	.imem_data(imem_data),
	.start(start)
);

instr_decode instr_decode_i (
	.clk(clk),
	.rst(rst),
	.imem_we(imem_we),
	.imem_addr(imem_addr),
	.imem_data(imem_data),
	.fetch_en(fetch_en),
	.branch_taken(branch_taken),
	.branch_target(branch_target),
	.dec(dec),
	.dec_valid(dec_valid)
);

execute_unit execute_unit_i (
	.clk(clk),
	.rst(rst),
	.start(start),
	.dec(dec),
	.dec_valid(dec_valid),
	.fetch_en(fetch_en),
	.branch_taken(branch_taken),
	.branch_target(branch_target),
	.rs1_addr(rs1_addr),
	.rs2_addr(rs2_addr),
	.rs1_data(rs1_data),
	.rs2_data(rs2_data),
	.transducer_l15_req(transducer_l15_req),
	.transducer_l15_val(transducer_l15_val),
	.l15_transducer_header_ack(l15_transducer_header_ack),
	.l15_transducer_resp(l15_transducer_resp),
	.l15_transducer_val(l15_transducer_val),
	.transducer_l15_req_ack(transducer_l15_req_ack),
	.wb_valid(wb_valid),
	.wb(wb),
	.halted(halted)
);

result_writeback result_writeback_i (
	.clk(clk),
	.rst(rst),
	.rs1_addr(rs1_addr),
	.rs2_addr(rs2_addr),
	.rs1_data(rs1_data),
	.rs2_data(rs2_data),
	.wb_valid(wb_valid),
	.wb(wb),
	.retire_valid(retire_valid),
	.retire(retire)
);

endmodule

/* result_writeback.sv */
`timescale 1ns/100ps

`include "core_settings.svh"

module result_writeback import core_isa_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic [REG_AW-1:0] rs1_addr,
	input  logic [REG_AW-1:0] rs2_addr,
	output logic [31:0]       rs1_data,
	output logic [31:0]       rs2_data,
	input  logic              wb_valid,
	input  retire_t           wb,
	output logic              retire_valid,
	output retire_t           retire
);

logic [31:0] regs [`NUM_REGS];

// Combinational read, r0 forced to zero
assign rs1_data = (rs1_addr == '0) ? 32'h0 : regs[rs1_addr];
assign rs2_data = (rs2_addr == '0) ? 32'h0 : regs[rs2_addr];

always_ff @(posedge clk)
begin
	if (rst)
	begin
		for (int i = 0; i < `NUM_REGS; i++)
			regs[i] <= 32'h0;
	end
	else if (wb_valid && (wb.rd != '0))
		regs[wb.rd] <= wb.data;
end

// Trace shows every write in its writeback cycle, r0 included
assign retire_valid = wb_valid;
assign retire = wb;

endmodule

/* execute_unit.sv */
`timescale 1ns/100ps

`include "core_settings.svh"

module execute_unit import core_isa_pkg::*, l15_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  decoded_t          dec,
	input  logic              dec_valid,
	output logic              fetch_en,
	output logic              branch_taken,
	output logic [PC_W-1:0]   branch_target,
	output logic [REG_AW-1:0] rs1_addr,
	output logic [REG_AW-1:0] rs2_addr,
	input  logic [31:0]       rs1_data,
	input  logic [31:0]       rs2_data,
	output l15_req_t          transducer_l15_req,
	output logic              transducer_l15_val,
	input  logic              l15_transducer_header_ack,
	input  l15_resp_t         l15_transducer_resp,
	input  logic              l15_transducer_val,
	output logic              transducer_l15_req_ack,
	output logic              wb_valid,
	output retire_t           wb,
	output logic              halted
);

typedef enum logic [2:0] {
	IDLE,
	FETCH,
	EXEC,
	MEM_REQ,
	MEM_WAIT,
	WRITEBACK,
	HALTED
} state_t;

state_t      state;
logic        exec_go;
logic        do_retire; // WRITEBACK writes a register
logic [31:0] alu_out;

assign rs1_addr = dec.rs1;
assign rs2_addr = dec.rs2;
assign exec_go = (state == EXEC) && dec_valid;

always_comb
begin
	case (dec.opcode)
		ADD:     alu_out = rs1_data + rs2_data;
		SUB:     alu_out = rs1_data - rs2_data;
		AND:     alu_out = rs1_data & rs2_data;
		OR:      alu_out = rs1_data | rs2_data;
		XOR:     alu_out = rs1_data ^ rs2_data;
		ADDI:    alu_out = rs1_data + dec.imm;
		LUI:     alu_out = {dec.imm[15:0], 16'h0000};
		default: alu_out = 32'h0;
	endcase
end

assign fetch_en = (state == FETCH);
assign branch_taken = exec_go && (dec.opcode == BEQ) && (rs1_data == rs2_data);
assign branch_target = dec.pc + dec.imm[PC_W-1:0]; // Wraps at memory size
assign transducer_l15_val = (state == MEM_REQ);
assign wb_valid = (state == WRITEBACK) && do_retire;
assign halted = (state == HALTED);

always_ff @(posedge clk)
begin
	if (rst)
	begin
		state <= IDLE;
		do_retire <= 1'b0;
		transducer_l15_req_ack <= 1'b0;
	end
	else
	begin
		transducer_l15_req_ack <= (state == MEM_WAIT) && l15_transducer_val;
		case (state)
			IDLE:
				if (start)
					state <= FETCH;
			FETCH:
				state <= EXEC;
			EXEC:
				if (dec_valid)
				begin
					do_retire <= 1'b0;
					case (dec.opcode)
						ADD, SUB, AND, OR, XOR, ADDI, LUI:
						begin
							state <= WRITEBACK;
							do_retire <= 1'b1;
						end
						LD:
						begin
							state <= MEM_REQ;
							do_retire <= 1'b1;
						end
						ST:      state <= MEM_REQ;
						HALT:    state <= HALTED;
						default: state <= WRITEBACK; // NOP, BEQ
					endcase
				end
			MEM_REQ:
				if (l15_transducer_header_ack)
					state <= MEM_WAIT;
			MEM_WAIT:
				if (l15_transducer_val)
					state <= (transducer_l15_req.rqtype == LOAD_RQ) ? WRITEBACK : FETCH;
			WRITEBACK:
				state <= FETCH;
			default:
				state <= HALTED; // Only reset leaves here
		endcase
	end
end

// Request is captured in EXEC and held through MEM_REQ
always_ff @(posedge clk)
begin
	if (exec_go)
	begin
		wb.rd <= dec.rd;
		wb.pc <= dec.pc;
		wb.data <= alu_out;
		transducer_l15_req.rqtype <= (dec.opcode == ST) ? STORE_RQ : LOAD_RQ;
		transducer_l15_req.size <= `L15_SIZE_WORD;
		transducer_l15_req.address <= rs1_data + dec.imm;
		transducer_l15_req.data <= {32'h0, rs2_data};
	end
	else if ((state == MEM_WAIT) && l15_transducer_val)
		wb.data <= l15_transducer_resp.data_0[31:0]; // Load result
end

endmodule

/* instr_decode.sv */
`timescale 1ns/100ps

`include "core_settings.svh"

module instr_decode import core_isa_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            imem_we,
	input  logic [PC_W-1:0] imem_addr,
	input  logic [31:0]     imem_data,
	input  logic            fetch_en,
	input  logic            branch_taken,
	input  logic [PC_W-1:0] branch_target,
	output decoded_t        dec,
	output logic            dec_valid
);

instr_t          imem [`IMEM_DEPTH];
logic [PC_W-1:0] pc;
instr_t          fetched;

assign fetched = imem[pc];

// Loader port
always_ff @(posedge clk)
begin
	if (imem_we)
		imem[imem_addr] <= instr_t'(imem_data);
end

// Program counter and decode strobe
always_ff @(posedge clk)
begin
	if (rst)
	begin
		pc <= '0;
		dec_valid <= 1'b0;
	end
	else
	begin
		dec_valid <= fetch_en;
		if (branch_taken)
			pc <= branch_target; // Resolved in execute
		else if (fetch_en)
			pc <= pc + 1'b1;
	end
end

// Field split
always_ff @(posedge clk)
begin
	if (fetch_en)
	begin
		dec.opcode <= fetched.opcode;
		dec.rd <= fetched.rd;
		dec.rs1 <= fetched.rs1;
		dec.rs2 <= fetched.rs2;
		dec.imm <= {{16{fetched.imm[15]}}, fetched.imm};
		dec.pc <= pc; // Address of this word, used for BEQ and retire
	end
end

endmodule

/* debug_loader.sv */
`timescale 1ns/100ps

`include "core_settings.svh"

module debug_loader (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           load_we,
	input  logic                           go,
	input  logic [$clog2(`IMEM_DEPTH)-1:0] load_addr,
	input  logic [31:0]                    load_instr,
	output logic                           imem_we,
	output logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr,
	output logic [31:0]                    imem_data,
	output logic                           start
);

// Control path
always_ff @(posedge clk)
begin
	if (rst)
	begin
		imem_we <= 1'b0;
		start <= 1'b0;
	end
	else
	begin
		imem_we <= load_we & ~start; // Program locked once running
		if (go)
			start <= 1'b1; // Sticky until reset
	end
end

// Write address and word, one cycle behind the strobe
always_ff @(posedge clk)
begin
	if (load_we)
	begin
		imem_addr <= load_addr;
		imem_data <= load_instr;
	end
end

endmodule

/* l15_pkg.sv */
package l15_pkg;

typedef enum logic [4:0] {
	LOAD_RQ  = 5'b00000,
	STORE_RQ = 5'b00001
} l15_rqtype_t;

typedef enum logic [4:0] {
	LOAD_RET = 5'b00000,
	ST_ACK   = 5'b00100
} l15_rettype_t;

// Request header and payload, store word in data[31:0]
typedef struct packed {
	l15_rqtype_t rqtype;
	logic [2:0]  size;
	logic [31:0] address;
	logic [63:0] data;
} l15_req_t;

typedef struct packed {
	l15_rettype_t returntype;
	logic [63:0]  data_0; // Load word in low half
} l15_resp_t;

endpackage

/* core_isa_pkg.sv */
package core_isa_pkg;

`include "core_settings.svh"

localparam int PC_W   = $clog2(`IMEM_DEPTH);
localparam int REG_AW = $clog2(`NUM_REGS);

typedef enum logic [3:0] {
	NOP  = 4'd0,
	ADD  = 4'd1,
	SUB  = 4'd2,
	AND  = 4'd3,
	OR   = 4'd4,
	XOR  = 4'd5,
	ADDI = 4'd6,
	LUI  = 4'd7,
	LD   = 4'd8,
	ST   = 4'd9,
	BEQ  = 4'd10,
	HALT = 4'd11
} opcode_t;

// Raw instruction word as held in instruction memory
typedef struct packed {
	opcode_t           opcode; // [31:28]
	logic [REG_AW-1:0] rd;     // [27:24]
	logic [REG_AW-1:0] rs1;    // [23:20]
	logic [REG_AW-1:0] rs2;    // [19:16]
	logic [15:0]       imm;    // [15:0]
} instr_t;

typedef struct packed {
	opcode_t           opcode;
	logic [REG_AW-1:0] rd;
	logic [REG_AW-1:0] rs1;
	logic [REG_AW-1:0] rs2;
	logic [31:0]       imm; // Sign extended
	logic [PC_W-1:0]   pc;
} decoded_t;

typedef struct packed {
	logic [REG_AW-1:0] rd;
	logic [31:0]       data;
	logic [PC_W-1:0]   pc;
} retire_t;

endpackage

/* core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Instruction memory size in 32-bit words
`define IMEM_DEPTH 64

// Architectural registers, r0 hardwired to zero
`define NUM_REGS 16

// L1.5 size encoding for a 4-byte access
`define L15_SIZE_WORD 3'b010

`endif
